/* rtl/obj_bus_pkg.sv */
// types for the shared video RAM read bus, referenced by scoped name from RTL and testbench
`default_nettype none

package obj_bus_pkg;

    // video RAM word address
    // bit 0 here is bit 1 of the byte address
    typedef logic [16:0] vram_addr_t;

    // one data word on the shared bus
    typedef logic [15:0] vram_word_t;

    // memory answer for the address currently on the bus
    // ok low means the data is not valid yet, so everything holds
    typedef struct packed {
        vram_word_t data;
        logic       ok;
    } vram_rsp_t;

endpackage

`default_nettype wire

/* rtl/obj_dma_ctrl.sv */
// DMA sequencer: bus request, table copy with terminator stop, zero fill and page swap
`timescale 1ns/10ps
`default_nettype none

`include "obj_macros.svh"

module obj_dma_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    obj_dma_ok,
    input  logic                    busack,
    input  obj_bus_pkg::vram_rsp_t  vram_rsp,
    input  logic                    last,
    output logic                    busreq,
    output logic                    load,
    output logic                    step,
    output obj_table_pkg::tbl_wr_t  wr,
    output logic                    rd_page
);

    obj_table_pkg::dma_state_t state;
    obj_table_pkg::obj_idx_t   idx;
    logic                      settle;
    logic                      restart;

    logic accept;
    logic term;
    logic start;
    logic abort;
    logic idx_end;

    always_comb begin
        // a read only counts on a pixel beat with the bus granted and data valid
        // settle skips the beat right after an accept while the new address propagates
        accept = (state == obj_table_pkg::COPY) && pxl_cen && busack
            && vram_rsp.ok && !settle;
        // attributes word is the first of each entry in fetch order
        term = (vram_rsp.data[15:8] == `OBJ_END_MARK) && (idx[1:0] == 2'b00);
        start = (state == obj_table_pkg::IDLE) && (obj_dma_ok || restart);
        // new frame while busy drops the copy
        abort = obj_dma_ok && (state != obj_table_pkg::IDLE);
        idx_end = (idx == obj_table_pkg::obj_idx_t'(`OBJ_WORDS - 1));
        load = start;
        step = accept && !term && !abort;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // power-up clears the page the renderer does not read yet
            state   <= obj_table_pkg::FILL;
            idx     <= '0;
            settle  <= 1'b0;
            restart <= 1'b0;
            rd_page <= 1'b0;
            busreq  <= 1'b0;
            wr      <= '0;
        end else begin
            wr.en <= 1'b0;
            if (abort) begin
                restart <= 1'b1;
                state   <= obj_table_pkg::IDLE;
            end else begin
                case (state)
                    obj_table_pkg::IDLE: begin
                        busreq <= 1'b0;
                        idx    <= '0;
                        settle <= 1'b1;
                        if (start) begin
                            // busreq stays high across a restart
                            busreq  <= 1'b1;
                            rd_page <= ~rd_page;
                            restart <= 1'b0;
                            state   <= obj_table_pkg::GRANT;
                        end
                    end
                    obj_table_pkg::GRANT: begin
                        if (busack) begin
                            state <= obj_table_pkg::COPY;
                        end
                    end
                    obj_table_pkg::COPY: begin
                        if (pxl_cen) begin
                            settle <= 1'b0;
                        end
                        if (accept) begin
                            if (term) begin
                                // terminator entry itself gets zeroed too
                                state <= obj_table_pkg::FILL;
                            end else begin
                                wr.en   <= 1'b1;
                                wr.page <= ~rd_page;
                                wr.idx  <= idx;
                                wr.data <= vram_rsp.data;
                                idx     <= idx + obj_table_pkg::obj_idx_t'(1);
                                settle  <= 1'b1;
                                // full table copied, no fill needed
                                if (last) begin
                                    state <= obj_table_pkg::IDLE;
                                end
                            end
                        end
                    end
                    obj_table_pkg::FILL: begin
                        // one zero per clock, no bus involved
                        wr.en   <= 1'b1;
                        wr.page <= ~rd_page;
                        wr.idx  <= idx;
                        wr.data <= '0;
                        idx     <= idx + obj_table_pkg::obj_idx_t'(1);
                        if (idx_end) begin
                            state <= obj_table_pkg::IDLE;
                        end
                    end
                    default: begin
                        state <= obj_table_pkg::IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_macros.svh */
// table sizes and terminator value for the object table DMA, included by packages and RTL
`ifndef OBJ_MACROS_SVH
`define OBJ_MACROS_SVH

// entries in one object table
`define OBJ_ENTRIES 256

// four 16-bit words per entry
// attributes sit at offset 3 and are fetched first
`define OBJ_WORDS (`OBJ_ENTRIES * 4)

// width of a word index within one page
`define OBJ_IDX_W 10

// upper byte of an attributes word that ends the table
`define OBJ_END_MARK 8'hFF

`endif

/* rtl/obj_table_buf.sv */
// double-buffered object table RAM, one page written by the DMA and one read by the renderer
`timescale 1ns/10ps
`default_nettype none

`include "obj_macros.svh"

module obj_table_buf (
    input  logic                      clk,
    input  logic                      rst,
    input  obj_table_pkg::tbl_wr_t    wr,
    input  logic                      rd_page,
    input  obj_table_pkg::obj_idx_t   table_addr,
    output obj_table_pkg::obj_word_t  table_data
);

    // two pages side by side, page bit on top
    obj_table_pkg::obj_word_t mem [0:2*`OBJ_WORDS-1];

    logic [`OBJ_IDX_W:0] wr_addr;
    logic [`OBJ_IDX_W:0] rd_addr;

    // low bits flipped back so entries land in natural order
    assign wr_addr = {wr.page, wr.idx[`OBJ_IDX_W-1:2], ~wr.idx[1:0]};
    assign rd_addr = {rd_page, table_addr};

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // registered read, one cycle after table_addr
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            table_data <= '0;
        end else begin
            table_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/obj_table_dma.sv */
// object table DMA top level: sequencer, video RAM address generator and table buffer
`timescale 1ns/10ps
`default_nettype none

module obj_table_dma (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      obj_dma_ok,
    input  logic                      busack,
    input  logic [15:0]               vram_base,
    input  obj_bus_pkg::vram_rsp_t    vram_rsp,
    input  obj_table_pkg::obj_idx_t   table_addr,
    output logic                      busreq,
    output obj_bus_pkg::vram_addr_t   vram_addr,
    output obj_table_pkg::obj_word_t  table_data
);

    logic                   load;
    logic                   step;
    logic                   last;
    logic                   rd_page;
    obj_table_pkg::tbl_wr_t wr;

    obj_dma_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .obj_dma_ok (obj_dma_ok),
        .busack     (busack),
        .vram_rsp   (vram_rsp),
        .last       (last),
        .busreq     (busreq),
        .load       (load),
        .step       (step),
        .wr         (wr),
        .rd_page    (rd_page)
    );

    obj_vram_addr u_addr (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .vram_base  (vram_base),
        .vram_addr  (vram_addr),
        .last       (last)
    );

    obj_table_buf u_buf (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .rd_page    (rd_page),
        .table_addr (table_addr),
        .table_data (table_data)
    );

endmodule

`default_nettype wire

/* rtl/obj_table_pkg.sv */
// types for object table entries, buffer writes and DMA states, referenced by scoped name
`default_nettype none

`include "obj_macros.svh"

package obj_table_pkg;

    // one word of the object table
    typedef logic [15:0] obj_word_t;

    // word index inside one page, natural order
    typedef logic [`OBJ_IDX_W-1:0] obj_idx_t;

    // single write into the double-buffered table
    // idx is the fetch-order index, the buffer undoes the reversal
    typedef struct packed {
        logic      en;
        logic      page;
        obj_idx_t  idx;
        obj_word_t data;
    } tbl_wr_t;

    // sequencer states
    // GRANT waits for the bus, FILL writes zeros to the page end
    typedef enum logic [1:0] {
        IDLE,
        GRANT,
        COPY,
        FILL
    } dma_state_t;

endpackage

`default_nettype wire

/* rtl/obj_vram_addr.sv */
// video RAM word counter for the table copy, emits the address in 3,2,1,0 entry order
`timescale 1ns/10ps
`default_nettype none

`include "obj_macros.svh"

module obj_vram_addr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    step,
    input  logic [15:0]             vram_base,
    output obj_bus_pkg::vram_addr_t vram_addr,
    output logic                    last
);

    obj_bus_pkg::vram_addr_t cnt;
    // words fetched since the base load
    logic [`OBJ_IDX_W-1:0]   ofs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            ofs <= '0;
        end else if (load) begin
            // table base is aligned to 256 words
            cnt <= {vram_base[9:1], 8'd0};
            ofs <= '0;
        end else if (step) begin
            cnt <= cnt + obj_bus_pkg::vram_addr_t'(1);
            ofs <= ofs + 1'b1;
        end
    end

    // counter runs 0,1,2,3 and the bus sees 3,2,1,0
    assign vram_addr = {cnt[16:2], ~cnt[1:0]};

    // sitting on the final word of the table range
    assign last = (ofs == `OBJ_IDX_W'(`OBJ_WORDS - 1));

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/obj_bus_pkg.sv
rtl/obj_table_pkg.sv
rtl/obj_vram_addr.sv
rtl/obj_table_buf.sv
rtl/obj_dma_ctrl.sv
rtl/obj_table_dma.sv
tests/obj_vram_model.sv
tests/obj_table_tb.sv

/* tests/obj_table_tb.sv */
// testbench for the object table DMA: runs a table of copies and checks the renderer page
`timescale 1ns/10ps
`default_nettype none

`include "obj_macros.svh"

module obj_table_tb;

    localparam int NUM_ROWS = 5;
    // two copies and two page reads per row, all well under ten cycles per word
    localparam int MAX_CYCLES = NUM_ROWS * 3 * `OBJ_WORDS * 10;
    // terminator position for a full table
    localparam int NO_TERM = 256;

    typedef struct packed {
        logic [15:0] base;
        logic [8:0]  term;
        logic        restart;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     pxl_cen;
    logic                     obj_dma_ok;
    logic                     busack;
    logic [15:0]              vram_base;
    obj_bus_pkg::vram_rsp_t   vram_rsp;
    obj_table_pkg::obj_idx_t  table_addr;
    logic                     busreq;
    obj_bus_pkg::vram_addr_t  vram_addr;
    obj_table_pkg::obj_word_t table_data;

    row_t                     rows [NUM_ROWS];
    string                    names [NUM_ROWS];
    obj_table_pkg::obj_word_t exp_page [`OBJ_WORDS];
    obj_table_pkg::obj_word_t prev_page [`OBJ_WORDS];
    logic [31:0]              lfsr;
    logic [31:0]              rnd;
    int                       cycle_cnt = 0;

    obj_table_dma UUT (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .obj_dma_ok (obj_dma_ok),
        .busack     (busack),
        .vram_base  (vram_base),
        .vram_rsp   (vram_rsp),
        .table_addr (table_addr),
        .busreq     (busreq),
        .vram_addr  (vram_addr),
        .table_data (table_data)
    );

    obj_vram_model vram (
        .clk       (clk),
        .rst       (rst),
        .busreq    (busreq),
        .vram_addr (vram_addr),
        .busack    (busack),
        .vram_rsp  (vram_rsp)
    );

    always #10 clk = ~clk;

    // pixel enable on every second beat
    always @(posedge clk) pxl_cen <= ~pxl_cen;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the DMA never finished within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    // Fibonacci LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic check_word(input string name, input int idx,
            input obj_table_pkg::obj_word_t exp, input obj_table_pkg::obj_word_t act);
        if (act !== exp) begin
            $display("ERROR %s word %0d: expected %h, actual %h", name, idx, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s busreq: expected %b, actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // random words at the table location, expected page built alongside
    task automatic load_table(input row_t row);
        logic [31:0]             w;
        obj_bus_pkg::vram_addr_t base_w;
        obj_bus_pkg::vram_addr_t a;
        int                      entry;
        base_w = {row.base[9:1], 8'd0};
        for (int i = 0; i < `OBJ_WORDS; i++) begin
            w = rand_bits(16);
            a = base_w + obj_bus_pkg::vram_addr_t'(i);
            entry = i / 4;
            // attributes sit at offset 3 of each entry
            if ((i % 4) == 3) begin
                if (entry == int'(row.term)) begin
                    w[15:8] = `OBJ_END_MARK;
                end else if (w[15:8] == `OBJ_END_MARK) begin
                    w[15:8] = 8'h7F;
                end
            end
            vram.mem[a] = w[15:0];
            exp_page[i] = (entry < int'(row.term)) ? w[15:0] : '0;
        end
    endtask

    // one-beat obj_dma_ok, busreq must be high one cycle later
    task automatic pulse_dma(input string name);
        @(posedge clk) obj_dma_ok <= 1'b1;
        @(posedge clk) obj_dma_ok <= 1'b0;
        @(negedge clk);
        check_level(name, 1'b1, busreq);
    endtask

    task automatic wait_idle();
        while (busreq) begin
            @(negedge clk);
        end
    endtask

    task automatic read_page(input string name, input bit use_prev);
        for (int i = 0; i < `OBJ_WORDS; i++) begin
            @(posedge clk) table_addr <= obj_table_pkg::obj_idx_t'(i);
            @(posedge clk);
            @(negedge clk);
            check_word(name, i, use_prev ? prev_page[i] : exp_page[i], table_data);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pxl_cen = 1'b0;
        obj_dma_ok = 1'b0;
        vram_base = '0;
        table_addr = '0;
        lfsr = 32'h671bbab7;
        rows[0] = '{16'h0000, 9'(NO_TERM), 1'b0};
        names[0] = "full_copy";
        rows[1] = '{16'h0246, 9'd37, 1'b0};
        names[1] = "term_mid";
        rnd = rand_bits(16);
        rows[2] = '{rnd[15:0], 9'd0, 1'b0};
        names[2] = "term_first";
        rnd = rand_bits(16);
        rows[3] = '{rnd[15:0], 9'(NO_TERM), 1'b1};
        names[3] = "restart";
        // base at the top of the range, table wraps around the address space
        rows[4] = '{16'h03FE, 9'd255, 1'b0};
        names[4] = "term_last_wrap";
        // page 1 is cleared by the power-up fill
        for (int i = 0; i < `OBJ_WORDS; i++) begin
            prev_page[i] = '0;
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_level("reset", 1'b0, busreq);
        check_word("reset", 0, '0, table_data);
        @(posedge clk) rst <= 1'b0;
        // zero fill takes one word per clock with the bus left alone
        repeat (`OBJ_WORDS + 8) begin
            @(negedge clk);
            check_level("reset_fill", 1'b0, busreq);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            load_table(rows[r]);
            @(posedge clk) vram_base <= rows[r].base;
            pulse_dma(names[r]);
            if (rows[r].restart) begin
                // busreq must hold high straight through the restart
                while (!busack) begin
                    @(negedge clk);
                    check_level(names[r], 1'b1, busreq);
                end
                repeat (100) begin
                    @(negedge clk);
                    check_level(names[r], 1'b1, busreq);
                end
                pulse_dma(names[r]);
                // the abort passes through IDLE without dropping the request
                @(negedge clk);
                check_level(names[r], 1'b1, busreq);
            end
            wait_idle();
            // renderer still shows the earlier table, the aborted page is not compared
            if (!rows[r].restart) begin
                read_page(names[r], 1'b1);
            end
            pulse_dma(names[r]);
            wait_idle();
            read_page(names[r], 1'b0);
            for (int i = 0; i < `OBJ_WORDS; i++) begin
                prev_page[i] = exp_page[i];
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/obj_vram_model.sv */
// testbench video RAM with delayed bus grant and random read latency, contents set by obj_table_tb
`timescale 1ns/10ps
`default_nettype none

module obj_vram_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    busreq,
    input  obj_bus_pkg::vram_addr_t vram_addr,
    output logic                    busack,
    output obj_bus_pkg::vram_rsp_t  vram_rsp
);

    // whole 17-bit word space, written from the testbench
    obj_bus_pkg::vram_word_t mem [0:(1<<17)-1];

    obj_bus_pkg::vram_addr_t cur_addr;
    logic [1:0]              req_dly;
    logic [1:0]              wait_cnt;
    logic [31:0]             lfsr;
    logic [31:0]             lfsr_a;
    logic [31:0]             lfsr_b;

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // two bits per new address give 0..3 extra wait beats
    assign lfsr_a = lfsr_step(lfsr);
    assign lfsr_b = lfsr_step(lfsr_a);

    // grant two cycles after the request, released together with it
    assign busack = busreq && req_dly[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_dly <= '0;
        end else begin
            req_dly <= busreq ? {req_dly[0], 1'b1} : 2'b00;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_addr <= '0;
            wait_cnt <= '0;
            lfsr     <= 32'h671bbab7;
            vram_rsp <= '0;
        end else if (vram_addr != cur_addr) begin
            // new address, data invalid until the latency runs out
            cur_addr    <= vram_addr;
            wait_cnt    <= {lfsr_a[0], lfsr_b[0]};
            lfsr        <= lfsr_b;
            vram_rsp.ok <= 1'b0;
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            // reloaded every beat so new contents between tables show up
            vram_rsp.ok   <= 1'b1;
            vram_rsp.data <= mem[cur_addr];
        end
    end

endmodule

`default_nettype wire
